/* project.f */
+incdir+.
pkt_pkg.sv
cmd_parser.sv
cmd_checker.sv
io_bank_ctrl.sv
resp_framer.sv
pkt_decode.sv
tb_pkt_decode.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the command decoder testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module tb_pkt_decode -f project.f -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
   exit 0
fi
echo "Testbench did not report success"
exit 1

/* tb_pkt_decode.sv */
// Directed testbench for the USB command decoder with a small IO reference model
`timescale 1ns/1ns
`include "pkt_cfg.svh"

module tb_pkt_decode;
   import pkt_pkg::*;

   localparam int RESP_WAIT  = 40;
   localparam int FRAME_MAX  = 16;
   localparam int QUIET_WAIT = 30;

   logic                      clk;
   logic                      i_arst_n;
   logic                      i_rx_vd;
   logic [`PKT_WORD_NBIT-1:0] i_rx_data;
   logic                      i_rx_sop;
   logic                      i_rx_eop;
   logic                      o_tx_vd;
   logic [`PKT_ADDR_NBIT:0]   o_tx_addr;
   logic [`PKT_WORD_NBIT-1:0] o_tx_data;
   logic                      o_tx_eop;
   logic [`IO_UNIT_NBIT-1:0]  i_io_db;
   logic [`IO_UNIT_NBIT-1:0]  o_io_dir;
   logic [`IO_UNIT_NBIT-1:0]  o_io_db;
   logic [`IO_BANK_NBIT-1:0]  o_io_bank;

   // Outgoing message, expected frame and received frame
   logic [`PKT_WORD_NBIT-1:0] msg_q[$];
   logic [`PKT_WORD_NBIT-1:0] exp_q[$];
   logic [`PKT_WORD_NBIT-1:0] rsp_data[$];
   logic [`PKT_ADDR_NBIT:0]   rsp_addr[$];
   bit                        frame_ok;

   int err_cnt;
   int chk_cnt;
   int test_cnt;
   int test_fail;
   int test_err0;

   // Reference IO state with stored values and driven pins
   logic [7:0] m_mask;
   logic [7:0] m_dir;
   logic [7:0] m_data;
   logic [7:0] m_out_dir;
   logic [7:0] m_out_db;
   logic [7:0] m_bank;

   pkt_decode dut_i (
      .clk       (clk),
      .i_arst_n  (i_arst_n),
      .i_rx_vd   (i_rx_vd),
      .i_rx_data (i_rx_data),
      .i_rx_sop  (i_rx_sop),
      .i_rx_eop  (i_rx_eop),
      .o_tx_vd   (o_tx_vd),
      .o_tx_addr (o_tx_addr),
      .o_tx_data (o_tx_data),
      .o_tx_eop  (o_tx_eop),
      .i_io_db   (i_io_db),
      .o_io_dir  (o_io_dir),
      .o_io_db   (o_io_db),
      .o_io_bank (o_io_bank)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////
   // ASCII helpers with the first character in the low byte
   function automatic logic [15:0] ascii_pair(input logic [7:0] first, input logic [7:0] second);
      return {second, first};
   endfunction

   function automatic logic [7:0] hex_digit(input logic [3:0] n);
      string digits;
      digits = "0123456789ABCDEF";
      return digits.getc(int'(n));
   endfunction

   // High nibble is the first character
   function automatic logic [15:0] hex_pair(input logic [7:0] b);
      return ascii_pair(hex_digit(b[7:4]), hex_digit(b[3:0]));
   endfunction

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      chk_cnt++;
      if (got !== exp) begin
         $display("Fail at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   ////////////////////
   // Reference model of the IO bank
   task automatic learn_set(input logic [7:0] mask, input logic [7:0] dir,
                            input logic [7:0] data);
      for (int b = 0; b < 8; b++) begin
         if (mask[b]) begin
            m_dir[b]  = 1'b0;
            m_data[b] = 1'b0;
         end else if (dir[b]) begin
            m_dir[b]  = 1'b1;
            m_data[b] = data[b];
         end else begin
            m_dir[b]  = 1'b0;
            m_data[b] = i_io_db[b];
         end
      end
      m_mask = mask;
   endtask

   task automatic learn_exe(input logic [7:0] bank);
      m_out_dir = m_dir;
      m_out_db  = m_data & ~m_mask;
      m_bank    = bank;
   endtask

   ////////////////////
   // Message building and driving
   task automatic start_msg(input logic [15:0] type_w, input logic [15:0] mode_w);
      msg_q.delete();
      msg_q.push_back(ascii_pair("@", "@"));
      msg_q.push_back(type_w);
      msg_q.push_back(mode_w);
   endtask

   task automatic add_hex(input logic [7:0] b);
      msg_q.push_back(hex_pair(b));
   endtask

   task automatic close_msg();
      msg_q.push_back(ascii_pair(8'h0D, 8'h0A));
   endtask

   // Called 1 ns after a rising edge, returns 1 ns after one
   task automatic send_msg(input bit abandon);
      i_rx_sop = 1'b1;
      @(posedge clk);
      #1;
      i_rx_sop = 1'b0;
      foreach (msg_q[i]) begin
         i_rx_vd   = 1'b1;
         i_rx_data = msg_q[i];
         @(posedge clk);
         #1;
      end
      i_rx_vd   = 1'b0;
      i_rx_data = '0;
      if (abandon) begin
         i_rx_eop = 1'b1;
         @(posedge clk);
         #1;
         i_rx_eop = 1'b0;
      end
   endtask

   // Frame words are sampled on the falling edge
   task automatic get_resp();
      int waited;
      int words;
      bit done;
      waited   = 0;
      words    = 0;
      done     = 1'b0;
      frame_ok = 1'b0;
      rsp_data.delete();
      rsp_addr.delete();
      @(negedge clk);
      while (!o_tx_vd && waited < RESP_WAIT) begin
         @(negedge clk);
         waited++;
      end
      if (!o_tx_vd) begin
         $display("No response frame started within %0d cycles", RESP_WAIT);
         err_cnt++;
      end else begin
         while (!done && words < FRAME_MAX) begin
            if (!o_tx_vd) begin
               $display("Response valid dropped after %0d words, before the end of frame",
                        words);
               err_cnt++;
               done = 1'b1;
            end else begin
               rsp_data.push_back(o_tx_data);
               rsp_addr.push_back(o_tx_addr);
               words++;
               if (o_tx_eop) begin
                  frame_ok = 1'b1;
                  done     = 1'b1;
               end else begin
                  @(negedge clk);
               end
            end
         end
         if (!done) begin
            $display("No end of frame seen within %0d words", FRAME_MAX);
            err_cnt++;
         end
      end
      @(posedge clk);
      #1;
   endtask

   ////////////////////
   // Expected responses
   task automatic expect_frame(input logic [15:0] type_w, input bit ok,
                               input logic [15:0] code_w, input bit io);
      exp_q.delete();
      exp_q.push_back(ascii_pair("@", "@"));
      exp_q.push_back(type_w);
      exp_q.push_back(ok ? ascii_pair("O", "K") : ascii_pair("N", "G"));
      exp_q.push_back(code_w);
      if (io) begin
         exp_q.push_back(hex_pair(m_mask));
         exp_q.push_back(hex_pair(m_dir));
         exp_q.push_back(hex_pair(m_data));
         exp_q.push_back(ascii_pair(8'h0A, 8'h0D));
      end
   endtask

   // Eop ends collection, so a matching length puts eop on the last word
   task automatic compare_frame(input bit io);
      check_eq(32'(rsp_data.size()), 32'(exp_q.size()), "frame length");
      foreach (exp_q[i]) begin
         if (i < rsp_data.size()) begin
            check_eq(32'(rsp_data[i]), 32'(exp_q[i]), $sformatf("frame word %0d", i));
            check_eq(32'(rsp_addr[i]), 32'({io, 4'(i)}), $sformatf("frame address %0d", i));
         end
      end
   endtask

   task automatic verify_io_pins();
      check_eq(32'(o_io_dir), 32'(m_out_dir), "IO direction");
      check_eq(32'(o_io_db), 32'(m_out_db), "IO data");
      check_eq(32'(o_io_bank), 32'(m_bank), "IO bank");
   endtask

   task automatic exchange(input bit io);
      send_msg(1'b0);
      get_resp();
      if (frame_ok)
         compare_frame(io);
   endtask

   task automatic expect_quiet(input int cycles);
      int n;
      bit seen;
      n    = 0;
      seen = 1'b0;
      while (n < cycles && !seen) begin
         @(negedge clk);
         if (o_tx_vd)
            seen = 1'b1;
         n++;
      end
      check_eq(32'(seen), 32'(0), "response frame sent where none was expected");
      @(posedge clk);
      #1;
   endtask

   task automatic finish_test(input string name);
      test_cnt++;
      if (err_cnt == test_err0) begin
         $display("Test %0d %s: ok", test_cnt, name);
      end else begin
         test_fail++;
         $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err0);
      end
      test_err0 = err_cnt;
   endtask

   ////////////////////
   // Tests
   task automatic handshake_test();
      start_msg(ascii_pair("0", "0"), ascii_pair("0", "1"));
      close_msg();
      expect_frame(ascii_pair("0", "0"), 1'b1, ascii_pair("0", "1"), 1'b0);
      exchange(1'b0);
      verify_io_pins();
      finish_test("handshake");
   endtask

   task automatic sex_test();
      logic [7:0] mask;
      logic [7:0] dir;
      logic [7:0] data;
      logic [7:0] bank;
      mask = 8'($urandom());
      dir  = 8'($urandom());
      data = 8'($urandom());
      bank = 8'($urandom());
      start_msg(ascii_pair("0", "2"), ascii_pair("0", "3"));
      add_hex(bank);
      add_hex(mask);
      add_hex(dir);
      add_hex(data);
      close_msg();
      learn_set(mask, dir, data);
      learn_exe(bank);
      expect_frame(ascii_pair("0", "2"), 1'b1, ascii_pair("2", "1"), 1'b1);
      exchange(1'b1);
      verify_io_pins();
      finish_test("IO set and execute");
   endtask

   task automatic set_then_exe_test();
      logic [7:0] mask;
      logic [7:0] dir;
      logic [7:0] data;
      logic [7:0] bank;
      mask = 8'($urandom());
      dir  = 8'($urandom());
      data = 8'($urandom());
      bank = 8'($urandom());
      start_msg(ascii_pair("0", "2"), ascii_pair("0", "1"));
      add_hex(8'h5A);
      add_hex(mask);
      add_hex(dir);
      add_hex(data);
      close_msg();
      learn_set(mask, dir, data);
      expect_frame(ascii_pair("0", "2"), 1'b1, ascii_pair("0", "1"), 1'b1);
      exchange(1'b1);
      // Pins keep the previous values until execute
      verify_io_pins();
      start_msg(ascii_pair("0", "2"), ascii_pair("0", "2"));
      add_hex(bank);
      close_msg();
      learn_exe(bank);
      expect_frame(ascii_pair("0", "2"), 1'b1, ascii_pair("1", "1"), 1'b1);
      exchange(1'b1);
      verify_io_pins();
      finish_test("IO set then execute");
   endtask

   task automatic error_test();
      // Bad digit in the first data word and clean words after it
      start_msg(ascii_pair("0", "2"), ascii_pair("0", "1"));
      add_hex(8'h01);
      msg_q.push_back(ascii_pair("G", "3"));
      add_hex(8'hF0);
      add_hex(8'h0F);
      close_msg();
      expect_frame(ascii_pair("0", "2"), 1'b0, ascii_pair("0", "3"), 1'b1);
      exchange(1'b1);
      verify_io_pins();
      // Two data bytes where three are needed
      start_msg(ascii_pair("0", "2"), ascii_pair("0", "3"));
      add_hex(8'h02);
      add_hex(8'hAA);
      add_hex(8'h55);
      close_msg();
      expect_frame(ascii_pair("0", "2"), 1'b0, ascii_pair("2", "2"), 1'b1);
      exchange(1'b1);
      verify_io_pins();
      start_msg(ascii_pair("0", "2"), ascii_pair("0", "7"));
      add_hex(8'h03);
      add_hex(8'h00);
      add_hex(8'hFF);
      add_hex(8'hFF);
      close_msg();
      expect_frame(ascii_pair("0", "2"), 1'b0, ascii_pair("0", "0"), 1'b1);
      exchange(1'b1);
      verify_io_pins();
      finish_test("error responses");
   endtask

   task automatic silence_test();
      start_msg(ascii_pair("0", "2"), ascii_pair("0", "3"));
      add_hex(8'h07);
      add_hex(8'h00);
      send_msg(1'b1);
      expect_quiet(QUIET_WAIT);
      verify_io_pins();
      start_msg(ascii_pair("0", "5"), ascii_pair("0", "1"));
      close_msg();
      send_msg(1'b0);
      expect_quiet(QUIET_WAIT);
      verify_io_pins();
      // Decoder still answers afterwards
      start_msg(ascii_pair("0", "0"), ascii_pair("0", "2"));
      close_msg();
      expect_frame(ascii_pair("0", "0"), 1'b1, ascii_pair("0", "1"), 1'b0);
      exchange(1'b0);
      finish_test("abandoned and unknown messages");
   endtask

   ////////////////////
   // Main sequence
   initial begin
      void'($urandom(43339));
      i_arst_n  = 1'b0;
      i_rx_vd   = 1'b0;
      i_rx_data = '0;
      i_rx_sop  = 1'b0;
      i_rx_eop  = 1'b0;
      i_io_db   = 8'($urandom());
      err_cnt   = 0;
      chk_cnt   = 0;
      test_cnt  = 0;
      test_fail = 0;
      test_err0 = 0;
      m_mask    = '0;
      m_dir     = '0;
      m_data    = '0;
      m_out_dir = '0;
      m_out_db  = '0;
      m_bank    = '0;
      repeat (5) @(posedge clk);
      #1;
      i_arst_n = 1'b1;
      handshake_test();
      sex_test();
      set_then_exe_test();
      error_test();
      silence_test();
      $display("Tests %0d, failed tests %0d, checks %0d, errors %0d",
               test_cnt, test_fail, chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

/* pkt_decode.sv */
// Top level of the USB command decoder: parser, checker, IO bank and response framer
`timescale 1ns/1ns
`include "pkt_cfg.svh"

module pkt_decode (
   input  logic                      clk,
   input  logic                      i_arst_n,
   input  logic                      i_rx_vd,
   input  logic [`PKT_WORD_NBIT-1:0] i_rx_data,
   input  logic                      i_rx_sop,
   input  logic                      i_rx_eop,
   output logic                      o_tx_vd,
   output logic [`PKT_ADDR_NBIT:0]   o_tx_addr,
   output logic [`PKT_WORD_NBIT-1:0] o_tx_data,
   output logic                      o_tx_eop,
   input  logic [`IO_UNIT_NBIT-1:0]  i_io_db,
   output logic [`IO_UNIT_NBIT-1:0]  o_io_dir,
   output logic [`IO_UNIT_NBIT-1:0]  o_io_db,
   output logic [`IO_BANK_NBIT-1:0]  o_io_bank
);
   import pkt_pkg::*;

   ////////////////////
   // Parser outputs
   logic                     msg_done;
   msg_type_t                msg_type;
   msg_mode_t                msg_mode;
   logic [`IO_BANK_NBIT-1:0] ch_addr;
   logic [`PKT_CNT_NBIT-1:0] data_cnt;
   logic                     msg_err;
   logic [`IO_UNIT_NBIT-1:0] new_mask;
   logic [`IO_UNIT_NBIT-1:0] new_dir;
   logic [`IO_UNIT_NBIT-1:0] new_data;

   ////////////////////
   // Checker and IO state
   logic                     resp_start;
   msg_type_t                resp_type;
   logic                     resp_pf;
   resp_code_t               resp_code;
   logic                     io_set;
   logic                     io_exe;
   logic [`IO_UNIT_NBIT-1:0] cur_mask;
   logic [`IO_UNIT_NBIT-1:0] cur_dir;
   logic [`IO_UNIT_NBIT-1:0] cur_data;

   cmd_parser u_parser (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_rx_vd    (i_rx_vd),
      .i_rx_data  (i_rx_data),
      .i_rx_sop   (i_rx_sop),
      .i_rx_eop   (i_rx_eop),
      .o_msg_done (msg_done),
      .o_msg_type (msg_type),
      .o_msg_mode (msg_mode),
      .o_ch_addr  (ch_addr),
      .o_data_cnt (data_cnt),
      .o_msg_err  (msg_err),
      .o_new_mask (new_mask),
      .o_new_dir  (new_dir),
      .o_new_data (new_data)
   );

   cmd_checker u_checker (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_msg_done   (msg_done),
      .i_msg_type   (msg_type),
      .i_msg_mode   (msg_mode),
      .i_data_cnt   (data_cnt),
      .i_msg_err    (msg_err),
      .o_resp_start (resp_start),
      .o_resp_type  (resp_type),
      .o_resp_pf    (resp_pf),
      .o_resp_code  (resp_code),
      .o_io_set     (io_set),
      .o_io_exe     (io_exe)
   );

   io_bank_ctrl u_io (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_io_set   (io_set),
      .i_io_exe   (io_exe),
      .i_new_mask (new_mask),
      .i_new_dir  (new_dir),
      .i_new_data (new_data),
      .i_ch_addr  (ch_addr),
      .i_io_db    (i_io_db),
      .o_io_dir   (o_io_dir),
      .o_io_db    (o_io_db),
      .o_io_bank  (o_io_bank),
      .o_cur_mask (cur_mask),
      .o_cur_dir  (cur_dir),
      .o_cur_data (cur_data)
   );

   resp_framer u_framer (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_resp_start (resp_start),
      .i_resp_type  (resp_type),
      .i_resp_pf    (resp_pf),
      .i_resp_code  (resp_code),
      .i_cur_mask   (cur_mask),
      .i_cur_dir    (cur_dir),
      .i_cur_data   (cur_data),
      .o_tx_vd      (o_tx_vd),
      .o_tx_addr    (o_tx_addr),
      .o_tx_data    (o_tx_data),
      .o_tx_eop     (o_tx_eop)
   );

endmodule

/* resp_framer.sv */
// Transmit FSM that builds the ASCII response frame word by word
`timescale 1ns/1ns
`include "pkt_cfg.svh"

module resp_framer (
   input  logic                      clk,
   input  logic                      i_arst_n,
   input  logic                      i_resp_start,
   input  pkt_pkg::msg_type_t        i_resp_type,
   input  logic                      i_resp_pf,
   input  pkt_pkg::resp_code_t       i_resp_code,
   input  logic [`IO_UNIT_NBIT-1:0]  i_cur_mask,
   input  logic [`IO_UNIT_NBIT-1:0]  i_cur_dir,
   input  logic [`IO_UNIT_NBIT-1:0]  i_cur_data,
   output logic                      o_tx_vd,
   output logic [`PKT_ADDR_NBIT:0]   o_tx_addr,
   output logic [`PKT_WORD_NBIT-1:0] o_tx_data,
   output logic                      o_tx_eop
);
   import pkt_pkg::*;

   localparam int SHR_NBIT = `IO_UNIT_NBIT * `IO_DATA_NUM;
   localparam int CNT_NBIT = $clog2(`IO_DATA_NUM);

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_TYPE,
      TX_PF,
      TX_CODE,
      TX_DATA,
      TX_END
   } tx_state_t;

   tx_state_t                 st;
   logic                      io_frame;
   logic [`PKT_ADDR_NBIT-1:0] word_addr;
   logic [CNT_NBIT-1:0]       data_left;
   logic [SHR_NBIT-1:0]       io_shr;
   logic [`IO_UNIT_NBIT-1:0]  io_byte;
   logic [`PKT_WORD_NBIT-1:0] hex_word;

   // High nibble goes out first, in the low byte
   assign io_byte   = io_shr[SHR_NBIT-1 -: `IO_UNIT_NBIT];
   assign hex_word  = {nibble_to_ascii(io_byte[3:0]), nibble_to_ascii(io_byte[7:4])};
   assign o_tx_addr = {io_frame, word_addr};

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         st        <= TX_IDLE;
         o_tx_vd   <= 1'b0;
         o_tx_eop  <= 1'b0;
         o_tx_data <= '0;
         io_frame  <= 1'b0;
         word_addr <= '0;
         data_left <= '0;
         io_shr    <= '0;
      end else begin
         o_tx_eop  <= 1'b0;
         word_addr <= word_addr + 1'b1;
         case (st)
            TX_IDLE: begin
               o_tx_vd <= 1'b0;
               // A start during a frame is never seen here
               if (i_resp_start) begin
                  o_tx_vd   <= 1'b1;
                  o_tx_data <= `MSG_HEAD;
                  word_addr <= '0;
                  io_frame  <= (i_resp_type == TYPE_IOCTRL);
                  st        <= TX_TYPE;
               end
            end
            TX_TYPE: begin
               o_tx_data <= i_resp_type;
               st        <= TX_PF;
            end
            TX_PF: begin
               o_tx_data <= i_resp_pf ? `MSG_PASS : `MSG_FAIL;
               st        <= TX_CODE;
            end
            TX_CODE: begin
               o_tx_data <= i_resp_code;
               if (io_frame) begin
                  // IO state has settled by now, mask first
                  io_shr    <= {i_cur_mask, i_cur_dir, i_cur_data};
                  data_left <= CNT_NBIT'(`IO_DATA_NUM - 1);
                  st        <= TX_DATA;
               end else begin
                  o_tx_eop <= 1'b1;
                  st       <= TX_IDLE;
               end
            end
            TX_DATA: begin
               o_tx_data <= hex_word;
               io_shr    <= io_shr << `IO_UNIT_NBIT;
               data_left <= data_left - 1'b1;
               if (data_left == '0)
                  st <= TX_END;
            end
            TX_END: begin
               o_tx_data <= {`MSG_END_R, `MSG_END_N};
               o_tx_eop  <= 1'b1;
               st        <= TX_IDLE;
            end
            default: begin
               o_tx_vd <= 1'b0;
               st      <= TX_IDLE;
            end
         endcase
      end
   end

   a_eop_in_frame: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_tx_eop |-> o_tx_vd);

endmodule

/* io_bank_ctrl.sv */
// IO bank control holding mask, direction and data and driving the IO port
`timescale 1ns/1ns
`include "pkt_cfg.svh"

module io_bank_ctrl (
   input  logic                     clk,
   input  logic                     i_arst_n,
   input  logic                     i_io_set,
   input  logic                     i_io_exe,
   input  logic [`IO_UNIT_NBIT-1:0] i_new_mask,
   input  logic [`IO_UNIT_NBIT-1:0] i_new_dir,
   input  logic [`IO_UNIT_NBIT-1:0] i_new_data,
   input  logic [`IO_BANK_NBIT-1:0] i_ch_addr,
   input  logic [`IO_UNIT_NBIT-1:0] i_io_db,
   output logic [`IO_UNIT_NBIT-1:0] o_io_dir,
   output logic [`IO_UNIT_NBIT-1:0] o_io_db,
   output logic [`IO_BANK_NBIT-1:0] o_io_bank,
   output logic [`IO_UNIT_NBIT-1:0] o_cur_mask,
   output logic [`IO_UNIT_NBIT-1:0] o_cur_dir,
   output logic [`IO_UNIT_NBIT-1:0] o_cur_data
);

   logic [`IO_UNIT_NBIT-1:0] eff_dir;
   logic [`IO_UNIT_NBIT-1:0] eff_data;
   logic [`IO_UNIT_NBIT-1:0] drv_mask;

   // dir 1 is output; a masked bit is an input reading 0
   assign eff_dir  = i_new_dir & ~i_new_mask;
   // Outputs take message data, open inputs sample the pins
   assign eff_data = (eff_dir & i_new_data) | (~eff_dir & ~i_new_mask & i_io_db);
   assign drv_mask = i_io_set ? i_new_mask : o_cur_mask;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_cur_mask <= '0;
         o_cur_dir  <= '0;
         o_cur_data <= '0;
         o_io_dir   <= '0;
         o_io_db    <= '0;
         o_io_bank  <= '0;
      end else begin
         if (i_io_set) begin
            o_cur_mask <= i_new_mask;
            o_cur_dir  <= eff_dir;
            o_cur_data <= eff_data;
         end
         // Set and execute together drive the new values straight away
         if (i_io_exe) begin
            o_io_dir  <= i_io_set ? eff_dir : o_cur_dir;
            o_io_db   <= (i_io_set ? eff_data : o_cur_data) & ~drv_mask;
            o_io_bank <= i_ch_addr;
         end
      end
   end

endmodule

/* cmd_checker.sv */
// Message checker that picks the verdict and response code and issues IO strobes
`timescale 1ns/1ns
`include "pkt_cfg.svh"

module cmd_checker (
   input  logic                     clk,
   input  logic                     i_arst_n,
   input  logic                     i_msg_done,
   input  pkt_pkg::msg_type_t       i_msg_type,
   input  pkt_pkg::msg_mode_t       i_msg_mode,
   input  logic [`PKT_CNT_NBIT-1:0] i_data_cnt,
   input  logic                     i_msg_err,
   output logic                     o_resp_start,
   output pkt_pkg::msg_type_t       o_resp_type,
   output logic                     o_resp_pf,
   output pkt_pkg::resp_code_t      o_resp_code,
   output logic                     o_io_set,
   output logic                     o_io_exe
);
   import pkt_pkg::*;

   localparam logic [`PKT_CNT_NBIT-1:0] FULL_CNT = `IO_DATA_NUM;

   logic       known;
   logic       pass;
   logic       do_set;
   logic       do_exe;
   resp_code_t code;

   ////////////////////
   // Verdict rules
   always_comb begin
      known  = 1'b1;
      pass   = 1'b0;
      do_set = 1'b0;
      do_exe = 1'b0;
      code   = CODE_00;
      case (i_msg_type)
         TYPE_HANDSHAKE: begin
            pass = 1'b1;
            code = CODE_01;
         end
         TYPE_IOCTRL: begin
            case (i_msg_mode)
               MODE_SET: begin
                  if (i_data_cnt != FULL_CNT)
                     code = CODE_02;
                  else if (i_msg_err)
                     code = CODE_03;
                  else begin
                     pass   = 1'b1;
                     do_set = 1'b1;
                     code   = CODE_01;
                  end
               end
               MODE_EXE: begin
                  // Execute takes no data
                  if (i_data_cnt == '0) begin
                     pass   = 1'b1;
                     do_exe = 1'b1;
                     code   = CODE_11;
                  end else
                     code = CODE_12;
               end
               MODE_SEX: begin
                  if (i_data_cnt != FULL_CNT)
                     code = CODE_22;
                  else if (i_msg_err)
                     code = CODE_23;
                  else begin
                     pass   = 1'b1;
                     do_set = 1'b1;
                     do_exe = 1'b1;
                     code   = CODE_21;
                  end
               end
               default: code = CODE_00;
            endcase
         end
         // Unknown types stay silent
         default: known = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_resp_start <= 1'b0;
         o_io_set     <= 1'b0;
         o_io_exe     <= 1'b0;
         o_resp_type  <= TYPE_HANDSHAKE;
         o_resp_pf    <= 1'b0;
         o_resp_code  <= CODE_00;
      end else begin
         o_resp_start <= i_msg_done & known;
         o_io_set     <= i_msg_done & do_set;
         o_io_exe     <= i_msg_done & do_exe;
         if (i_msg_done && known) begin
            o_resp_type <= i_msg_type;
            o_resp_pf   <= pass;
            o_resp_code <= code;
         end
      end
   end

   a_exe_has_resp: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_io_exe |-> o_resp_start);

endmodule

/* cmd_parser.sv */
// Receive FSM that splits incoming USB words into message fields and data bytes
`timescale 1ns/1ns
`include "pkt_cfg.svh"

module cmd_parser (
   input  logic                      clk,
   input  logic                      i_arst_n,
   input  logic                      i_rx_vd,
   input  logic [`PKT_WORD_NBIT-1:0] i_rx_data,
   input  logic                      i_rx_sop,
   input  logic                      i_rx_eop,
   output logic                      o_msg_done,
   output pkt_pkg::msg_type_t        o_msg_type,
   output pkt_pkg::msg_mode_t        o_msg_mode,
   output logic [`IO_BANK_NBIT-1:0]  o_ch_addr,
   output logic [`PKT_CNT_NBIT-1:0]  o_data_cnt,
   output logic                      o_msg_err,
   output logic [`IO_UNIT_NBIT-1:0]  o_new_mask,
   output logic [`IO_UNIT_NBIT-1:0]  o_new_dir,
   output logic [`IO_UNIT_NBIT-1:0]  o_new_data
);
   import pkt_pkg::*;

   localparam int SHR_NBIT = `PKT_BYTE_NBIT * `IO_DATA_NUM;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_HEAD,
      ST_TYPE,
      ST_MODE,
      ST_CHAN,
      ST_DATA,
      ST_END
   } rx_state_t;

   rx_state_t                 st;
   logic [SHR_NBIT-1:0]       data_shr;
   logic [`PKT_BYTE_NBIT-1:0] rx_byte;
   logic                      hi_err;
   logic                      lo_err;
   logic                      rx_byte_err;
   logic                      is_end;

   ////////////////////
   // Hex decode of the current word
   // First character is the high nibble
   always_comb begin
      rx_byte[7:4] = ascii_to_nibble(i_rx_data[`PKT_BYTE_NBIT-1:0], hi_err);
      rx_byte[3:0] = ascii_to_nibble(i_rx_data[`PKT_WORD_NBIT-1:`PKT_BYTE_NBIT], lo_err);
      rx_byte_err  = hi_err | lo_err;
   end

   assign is_end = (i_rx_data[`PKT_BYTE_NBIT-1:0] == `MSG_END_N) ||
                   (i_rx_data[`PKT_BYTE_NBIT-1:0] == `MSG_END_R);

   ////////////////////
   // Receive FSM
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         st         <= ST_IDLE;
         o_msg_done <= 1'b0;
         o_msg_type <= msg_type_t'(0);
         o_msg_mode <= msg_mode_t'(0);
         o_ch_addr  <= '0;
         o_data_cnt <= '0;
         o_msg_err  <= 1'b0;
         data_shr   <= '0;
      end else begin
         o_msg_done <= (st == ST_END);
         if (i_rx_eop) begin
            // Abandon whatever is in flight
            st <= ST_IDLE;
         end else begin
            case (st)
               ST_IDLE: begin
                  if (i_rx_sop) begin
                     st         <= ST_HEAD;
                     o_msg_type <= msg_type_t'(0);
                     o_msg_mode <= msg_mode_t'(0);
                     o_ch_addr  <= '0;
                     o_data_cnt <= '0;
                     o_msg_err  <= 1'b0;
                     data_shr   <= '0;
                  end
               end
               ST_HEAD: begin
                  if (i_rx_vd && i_rx_data == `MSG_HEAD)
                     st <= ST_TYPE;
               end
               ST_TYPE: begin
                  if (i_rx_vd) begin
                     o_msg_type <= msg_type_t'(i_rx_data);
                     st         <= ST_MODE;
                  end
               end
               ST_MODE: begin
                  if (i_rx_vd) begin
                     if (is_end) begin
                        st <= ST_END;
                     end else begin
                        o_msg_mode <= msg_mode_t'(i_rx_data);
                        st         <= ST_CHAN;
                     end
                  end
               end
               ST_CHAN: begin
                  if (i_rx_vd) begin
                     if (is_end) begin
                        st <= ST_END;
                     end else begin
                        o_ch_addr <= rx_byte;
                        o_msg_err <= o_msg_err | rx_byte_err;
                        st        <= ST_DATA;
                     end
                  end
               end
               ST_DATA: begin
                  if (i_rx_vd) begin
                     if (is_end) begin
                        st <= ST_END;
                     end else begin
                        data_shr  <= {data_shr[SHR_NBIT-`PKT_BYTE_NBIT-1:0], rx_byte};
                        o_msg_err <= o_msg_err | rx_byte_err;
                        // Saturate so a long message never looks like a short one
                        if (o_data_cnt != '1)
                           o_data_cnt <= o_data_cnt + 1'b1;
                     end
                  end
               end
               ST_END:  st <= ST_IDLE;
               default: st <= ST_IDLE;
            endcase
         end
      end
   end

   // Last three bytes, oldest first
   assign o_new_mask = data_shr[SHR_NBIT-1 -: `IO_UNIT_NBIT];
   assign o_new_dir  = data_shr[2*`IO_UNIT_NBIT-1 -: `IO_UNIT_NBIT];
   assign o_new_data = data_shr[`IO_UNIT_NBIT-1:0];

   a_done_single: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_msg_done |=> !o_msg_done);

endmodule

/* pkt_pkg.sv */
// Message types, response codes and ASCII hex helpers for the command decoder
`include "pkt_cfg.svh"

package pkt_pkg;

   // Two characters per word, first one in the low byte
   typedef enum logic [`PKT_WORD_NBIT-1:0] {
      TYPE_HANDSHAKE = 16'h3030,   // "00"
      TYPE_IOCTRL    = 16'h3230    // "02"
   } msg_type_t;

   typedef enum logic [`PKT_WORD_NBIT-1:0] {
      MODE_SET = 16'h3130,         // "01"
      MODE_EXE = 16'h3230,         // "02"
      MODE_SEX = 16'h3330          // "03", set and execute
   } msg_mode_t;

   // Verdict code sent after the OK/NG word
   typedef enum logic [`PKT_WORD_NBIT-1:0] {
      CODE_00 = 16'h3030,
      CODE_01 = 16'h3130,
      CODE_02 = 16'h3230,
      CODE_03 = 16'h3330,
      CODE_11 = 16'h3131,
      CODE_12 = 16'h3231,
      CODE_21 = 16'h3132,
      CODE_22 = 16'h3232,
      CODE_23 = 16'h3332
   } resp_code_t;

   // 0-9, a-f, A-F; anything else flags an error
   function automatic logic [3:0] ascii_to_nibble(input logic [`PKT_BYTE_NBIT-1:0] c,
                                                  output logic err);
      logic [`PKT_BYTE_NBIT-1:0] v;
      err = 1'b0;
      v   = '0;
      if (c >= "0" && c <= "9")
         v = c - "0";
      else if (c >= "a" && c <= "f")
         v = c - "a" + 8'd10;
      else if (c >= "A" && c <= "F")
         v = c - "A" + 8'd10;
      else
         err = 1'b1;
      return v[3:0];
   endfunction

   // Upper case for A-F
   function automatic logic [`PKT_BYTE_NBIT-1:0] nibble_to_ascii(input logic [3:0] n);
      return (n < 4'd10) ? ("0" + {4'h0, n}) : ("A" - 8'd10 + {4'h0, n});
   endfunction

endpackage

/* pkt_cfg.svh */
// Widths, character codes and frame constants for the USB command decoder
`ifndef PKT_CFG_SVH
`define PKT_CFG_SVH

////////////////////
// Bus widths
`define PKT_WORD_NBIT 16
`define PKT_BYTE_NBIT 8
`define PKT_CNT_NBIT  4
`define PKT_ADDR_NBIT 4
`define IO_UNIT_NBIT  8
`define IO_BANK_NBIT  8

// Data bytes of an IO set: mask, direction, data
`define IO_DATA_NUM   3

////////////////////
// Character codes, first character in the low byte
`define MSG_HEAD  16'h4040
`define MSG_END_N 8'h0A
`define MSG_END_R 8'h0D
`define MSG_PASS  16'h4B4F
`define MSG_FAIL  16'h474E

`endif
